// File: compile.f
ecc_pkg.sv
ecc_encoder.sv
ecc_error_inject.sv
ecc_decoder.sv
ecc_ctrl.sv
ecc_top.sv
tb_ecc_top.sv

// File: ecc_ctrl.sv
`timescale 1ns/1ps

module ecc_ctrl #(
  parameter bit register_syndrome = 1'b0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  ecc_pkg::ecc_req_t    in_req,
  input  logic                 dec_valid,
  input  ecc_pkg::ecc_result_t dec_res,
  output ecc_pkg::ecc_stats_t  stats,
  output logic                 error
);

  // Same depth as encoder, injector and decoder together
  localparam int depth = 3 + int'(register_syndrome);

  typedef struct packed {
    logic [ecc_pkg::data_width-1:0] data;
    ecc_pkg::ecc_class_e            cls;
  } exp_t;

  logic [1:0]          n_flips;
  ecc_pkg::ecc_class_e exp_cls;
  logic [depth-1:0]    pipe_valid;
  exp_t                pipe [depth];
  exp_t                head;
  logic                class_ok;
  logic                data_ok;
  logic                mismatch;

  // Count distinct flipped positions
  always_comb begin
    n_flips = 2'(in_req.inj.flip0_en) + 2'(in_req.inj.flip1_en);
    if (in_req.inj.flip0_en && in_req.inj.flip1_en &&
        (in_req.inj.flip0_idx == in_req.inj.flip1_idx)) begin
      n_flips = 2'd0;
    end
    case (n_flips)
      2'd0: exp_cls = ecc_pkg::clean;
      2'd1: exp_cls = ecc_pkg::ce;
      default: exp_cls = ecc_pkg::due;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid <= {pipe_valid[depth-2:0], in_valid};
    end
  end

  // Expected data and class travel beside the valid bits
  always_ff @(posedge clk) begin
    pipe[0] <= '{data: in_req.data, cls: exp_cls};
    for (int i = 1; i < depth; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign head = pipe[depth-1];

  always_comb begin
    case (head.cls)
      ecc_pkg::clean: class_ok = !dec_res.ce && !dec_res.due;
      ecc_pkg::ce: class_ok = dec_res.ce && !dec_res.due;
      default: class_ok = dec_res.due && !dec_res.ce;
    endcase
    // Data after a double error is not meaningful
    data_ok = (head.cls == ecc_pkg::due) || (dec_res.data == head.data);
    mismatch = dec_valid && !(class_ok && data_ok);
  end

  // Counters land one cycle after the decoder strobe and hold at all ones
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stats <= '0;
      error <= 1'b0;
    end else begin
      if (dec_valid && dec_res.ce && (stats.ce_count != '1)) begin
        stats.ce_count <= stats.ce_count + 1'b1;
      end
      if (dec_valid && dec_res.due && (stats.due_count != '1)) begin
        stats.due_count <= stats.due_count + 1'b1;
      end
      if (mismatch && (stats.mismatch_count != '1)) begin
        stats.mismatch_count <= stats.mismatch_count + 1'b1;
      end
      if (mismatch) begin
        error <= 1'b1;
      end
    end
  end

  // Delay line stays aligned with the whole datapath
  align_a: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid == pipe_valid[depth-1]);

  ce_sat_a: assert property (@(posedge clk) disable iff (!rst_n)
    (stats.ce_count == '1) |=> (stats.ce_count == '1));
  due_sat_a: assert property (@(posedge clk) disable iff (!rst_n)
    (stats.due_count == '1) |=> (stats.due_count == '1));
  mis_sat_a: assert property (@(posedge clk) disable iff (!rst_n)
    (stats.mismatch_count == '1) |=> (stats.mismatch_count == '1));

endmodule

// File: ecc_decoder.sv
`timescale 1ns/1ps

module ecc_decoder #(
  parameter bit register_syndrome = 1'b0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rcv_valid,
  input  ecc_pkg::ecc_codeword_u rcv_cw,
  output logic                   dec_valid,
  output ecc_pkg::ecc_result_t   dec_res
);

  logic [ecc_pkg::parity_width-1:0] syn_comb;
  // Syndrome stage outputs in either build
  logic                             stg_valid;
  ecc_pkg::ecc_codeword_u           stg_cw;
  logic [ecc_pkg::parity_width-1:0] stg_syn;
  // Classification
  logic [ecc_pkg::data_width-1:0]   corr_data;
  logic                             col_hit;
  logic                             syn_odd;
  logic                             syn_unit;
  logic                             is_ce;
  logic                             is_due;

  // Recomputed parity against the parity that arrived
  assign syn_comb = ecc_pkg::calc_parity(rcv_cw.fields.data) ^ rcv_cw.fields.parity;

  if (register_syndrome) begin : gen_syn_reg
    // Extra pipeline cycle with its own strobe
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        stg_valid <= 1'b0;
      end else begin
        stg_valid <= rcv_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (rcv_valid) begin
        stg_cw <= rcv_cw;
        stg_syn <= syn_comb;
      end
    end
  end else begin : gen_syn_comb
    assign stg_valid = rcv_valid;
    assign stg_cw = rcv_cw;
    assign stg_syn = syn_comb;
  end

  always_comb begin
    corr_data = stg_cw.fields.data;
    col_hit = 1'b0;
    // A data column match points at the flipped data bit
    for (int i = 0; i < ecc_pkg::data_width; i++) begin
      if (stg_syn == ecc_pkg::hsiao_cols[i]) begin
        corr_data[i] = ~corr_data[i];
        col_hit = 1'b1;
      end
    end
    syn_odd = ^stg_syn;
    // Unit vector means a flipped parity bit and intact data
    syn_unit = $onehot(stg_syn);
    is_ce = syn_odd && (col_hit || syn_unit);
    // Even nonzero weight or an odd weight with no matching column
    is_due = (stg_syn != '0) && (!syn_odd || (!col_hit && !syn_unit));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= stg_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stg_valid) begin
      dec_res.data <= corr_data;
      dec_res.ce <= is_ce;
      dec_res.due <= is_due;
      dec_res.syndrome <= stg_syn;
    end
  end

  flags_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> !(dec_res.ce && dec_res.due));

endmodule

// File: ecc_encoder.sv
`timescale 1ns/1ps

module ecc_encoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  ecc_pkg::ecc_req_t     in_req,
  output logic                  enc_valid,
  output ecc_pkg::ecc_codeword_u enc_cw,
  output ecc_pkg::ecc_inj_t     enc_inj
);

  ecc_pkg::ecc_codeword_u cw_next;

  // Systematic codeword, data passes through unchanged
  always_comb begin
    cw_next.fields.data = in_req.data;
    cw_next.fields.parity = ecc_pkg::calc_parity(in_req.data);
  end

  // Strobe register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enc_valid <= 1'b0;
    end else begin
      enc_valid <= in_valid;
    end
  end

  // Codeword and its injection request move together
  always_ff @(posedge clk) begin
    if (in_valid) begin
      enc_cw <= cw_next;
      enc_inj <= in_req.inj;
    end
  end

endmodule

// File: ecc_error_inject.sv
`timescale 1ns/1ps

module ecc_error_inject (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enc_valid,
  input  ecc_pkg::ecc_codeword_u enc_cw,
  input  ecc_pkg::ecc_inj_t      enc_inj,
  output logic                   rcv_valid,
  output ecc_pkg::ecc_codeword_u rcv_cw
);

  logic [ecc_pkg::cw_width-1:0] flip_mask;

  // One mask bit per codeword position
  // XOR of both hits so a repeated index cancels out
  always_comb begin
    for (int i = 0; i < ecc_pkg::cw_width; i++) begin
      flip_mask[i] = (enc_inj.flip0_en && (enc_inj.flip0_idx == ecc_pkg::idx_width'(i))) ^
                     (enc_inj.flip1_en && (enc_inj.flip1_idx == ecc_pkg::idx_width'(i)));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rcv_valid <= 1'b0;
    end else begin
      rcv_valid <= enc_valid;
    end
  end

  // Corrupted word on the raw view
  always_ff @(posedge clk) begin
    if (enc_valid) begin
      rcv_cw.raw <= enc_cw.raw ^ flip_mask;
    end
  end

  // Indices 13 to 15 name no codeword bit and would be dropped silently
  idx_range_a: assert property (@(posedge clk) disable iff (!rst_n)
    enc_valid |-> (!enc_inj.flip0_en || (enc_inj.flip0_idx < ecc_pkg::cw_width)) &&
                  (!enc_inj.flip1_en || (enc_inj.flip1_idx < ecc_pkg::cw_width)));

endmodule

// File: ecc_pkg.sv
package ecc_pkg;

  // Fixed SECDED geometry for an 8-bit message
  localparam int data_width = 8;
  localparam int parity_width = 5;
  localparam int cw_width = data_width + parity_width;
  localparam int idx_width = 4;
  localparam int cnt_width = 16;

  // Hsiao H-matrix data columns, listed from data bit 7 down to bit 0
  // Each column has weight 3 and every column is distinct
  localparam logic [data_width-1:0][parity_width-1:0] hsiao_cols = {
    5'b11001, 5'b10110, 5'b10101, 5'b10011,
    5'b01110, 5'b01101, 5'b01011, 5'b00111
  };

  // Field view of a codeword with parity on top
  typedef struct packed {
    logic [parity_width-1:0] parity;
    logic [data_width-1:0]   data;
  } ecc_cw_fields_t;

  // Codeword read either flat or as fields
  typedef union packed {
    logic [cw_width-1:0] raw;
    ecc_cw_fields_t      fields;
  } ecc_codeword_u;

  typedef struct packed {
    logic                 flip0_en;
    logic [idx_width-1:0] flip0_idx;
    logic                 flip1_en;
    logic [idx_width-1:0] flip1_idx;
  } ecc_inj_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    ecc_inj_t              inj;
  } ecc_req_t;

  typedef enum logic [1:0] {
    clean = 2'd0,
    ce    = 2'd1,
    due   = 2'd2
  } ecc_class_e;

  typedef struct packed {
    logic [data_width-1:0]   data;
    logic                    ce;
    logic                    due;
    logic [parity_width-1:0] syndrome;
  } ecc_result_t;

  typedef struct packed {
    logic [cnt_width-1:0] ce_count;
    logic [cnt_width-1:0] due_count;
    logic [cnt_width-1:0] mismatch_count;
  } ecc_stats_t;

  // Parity of a message, shared by encoder and decoder
  // Parity bit j is the XOR of every data bit whose column has bit j set
  function automatic logic [parity_width-1:0] calc_parity(
    input logic [data_width-1:0] data
  );
    logic [parity_width-1:0] parity;
    parity = '0;
    for (int i = 0; i < data_width; i++) begin
      if (data[i]) begin
        parity = parity ^ hsiao_cols[i];
      end
    end
    return parity;
  endfunction

endpackage

// File: ecc_top.sv
`timescale 1ns/1ps

module ecc_top #(
  parameter bit register_syndrome = 1'b0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  ecc_pkg::ecc_req_t    in_req,
  output logic                 out_valid,
  output ecc_pkg::ecc_result_t out_res,
  output ecc_pkg::ecc_stats_t  stats,
  output logic                 error
);

  // Encoder to injector
  logic                   enc_valid;
  ecc_pkg::ecc_codeword_u enc_cw;
  ecc_pkg::ecc_inj_t      enc_inj;
  // Injector to decoder
  logic                   rcv_valid;
  ecc_pkg::ecc_codeword_u rcv_cw;

  ecc_encoder u_encoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .enc_valid (enc_valid),
    .enc_cw    (enc_cw),
    .enc_inj   (enc_inj)
  );

  ecc_error_inject u_inject (
    .clk       (clk),
    .rst_n     (rst_n),
    .enc_valid (enc_valid),
    .enc_cw    (enc_cw),
    .enc_inj   (enc_inj),
    .rcv_valid (rcv_valid),
    .rcv_cw    (rcv_cw)
  );

  // Decoder result is both the top output and the checker input
  ecc_decoder #(
    .register_syndrome (register_syndrome)
  ) u_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .rcv_valid (rcv_valid),
    .rcv_cw    (rcv_cw),
    .dec_valid (out_valid),
    .dec_res   (out_res)
  );

  ecc_ctrl #(
    .register_syndrome (register_syndrome)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .dec_valid (out_valid),
    .dec_res   (out_res),
    .stats     (stats),
    .error     (error)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ecc_top -f compile.f -o tb_ecc_top

./obj_dir/tb_ecc_top 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation clean"

// File: tb_ecc_top.sv
`timescale 1ns/1ps

module tb_ecc_top;

  // Word count over the clean, single, double with same-index pairs, and mixed tests
  localparam int n_words = 20 + 13 + 34 + 200;
  localparam int max_gap = 3;
  // Worst case of a full gap after every word plus reset and drain margin
  localparam int limit_cycles = n_words * (max_gap + 1) + 5 + 50;

  // One outstanding word as the reference model sees it
  typedef struct packed {
    logic [ecc_pkg::data_width-1:0]   data;
    ecc_pkg::ecc_class_e              cls;
    logic [ecc_pkg::parity_width-1:0] syn;
  } exp_t;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  ecc_pkg::ecc_req_t    in_req;
  logic                 out_valid;
  ecc_pkg::ecc_result_t out_res;
  ecc_pkg::ecc_stats_t  stats;
  logic                 error;

  int   seed;
  int   err_count;
  int   errs_at_start;
  int   tests_passed;
  int   tests_failed;
  int   ce_tally;
  int   due_tally;
  exp_t exp_q[$];
  exp_t head;
  logic have_head;

  ecc_top #(
    .register_syndrome (1'b0)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_res   (out_res),
    .stats     (stats),
    .error     (error)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // H-matrix column of a codeword position with unit vectors above the data
  function automatic logic [ecc_pkg::parity_width-1:0] column_of(int pos);
    if (pos < ecc_pkg::data_width) begin
      return ecc_pkg::hsiao_cols[pos];
    end
    return ecc_pkg::parity_width'(1) << (pos - ecc_pkg::data_width);
  endfunction

  // Syndrome is the XOR of the columns of all flipped positions
  function automatic logic [ecc_pkg::parity_width-1:0] expected_syndrome(
    ecc_pkg::ecc_inj_t inj
  );
    logic [ecc_pkg::parity_width-1:0] syn;
    syn = '0;
    if (inj.flip0_en) begin
      syn = syn ^ column_of(int'(inj.flip0_idx));
    end
    if (inj.flip1_en) begin
      syn = syn ^ column_of(int'(inj.flip1_idx));
    end
    return syn;
  endfunction

  // Class follows the number of distinct flipped positions
  function automatic ecc_pkg::ecc_class_e expected_class(ecc_pkg::ecc_inj_t inj);
    int n;
    n = int'(inj.flip0_en) + int'(inj.flip1_en);
    if (inj.flip0_en && inj.flip1_en && (inj.flip0_idx == inj.flip1_idx)) begin
      n = 0;
    end
    if (n == 0) begin
      return ecc_pkg::clean;
    end
    return (n == 1) ? ecc_pkg::ce : ecc_pkg::due;
  endfunction

  function automatic ecc_pkg::ecc_inj_t make_inj(bit en0, int idx0, bit en1, int idx1);
    ecc_pkg::ecc_inj_t inj;
    inj.flip0_en = en0;
    inj.flip0_idx = ecc_pkg::idx_width'(idx0);
    inj.flip1_en = en1;
    inj.flip1_idx = ecc_pkg::idx_width'(idx1);
    return inj;
  endfunction

  task automatic value_fail(string name, int exp, int act);
    $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic flow_fail(string msg);
    $display("Error at t=%0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic check_value(string name, int exp, int act);
    assert (exp == act) else value_fail(name, exp, act);
  endtask

  // One word on the next rising edge
  task automatic send_word(logic [ecc_pkg::data_width-1:0] data, ecc_pkg::ecc_inj_t inj);
    @(posedge clk);
    in_valid <= 1'b1;
    in_req <= '{data: data, inj: inj};
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // Wait until every outstanding word has come back
  task automatic drain();
    idle(1);
    do begin
      @(negedge clk);
    end while (exp_q.size() != 0);
    @(negedge clk);
  endtask

  task automatic begin_test();
    errs_at_start = err_count;
  endtask

  task automatic finish_test(string name);
    if (err_count == errs_at_start) begin
      $display("test %s: passed", name);
      tests_passed++;
    end else begin
      $display("test %s: failed", name);
      tests_failed++;
    end
  endtask

  // Reference queue pops on each result and pushes on each accepted word
  always @(posedge clk) begin
    if (rst_n && out_valid && (exp_q.size() > 0)) begin
      if (exp_q[0].cls == ecc_pkg::ce) begin
        ce_tally++;
      end else if (exp_q[0].cls == ecc_pkg::due) begin
        due_tally++;
      end
      void'(exp_q.pop_front());
    end
    if (rst_n && in_valid) begin
      exp_q.push_back('{data: in_req.data, cls: expected_class(in_req.inj),
                        syn: expected_syndrome(in_req.inj)});
    end
    have_head = (exp_q.size() > 0);
    head = have_head ? exp_q[0] : '0;
  end

  latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == $past(in_valid, 3))
    else flow_fail("out_valid did not follow in_valid by 3 cycles");
  order_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> have_head)
    else flow_fail("result arrived with no word outstanding");
  // Data after a double error carries no meaning
  data_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && have_head && (head.cls != ecc_pkg::due)) |-> (out_res.data == head.data))
    else value_fail("out_res.data", int'($sampled(head.data)), int'($sampled(out_res.data)));
  ce_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && have_head) |-> (out_res.ce == (head.cls == ecc_pkg::ce)))
    else value_fail("out_res.ce", int'($sampled(head.cls) == ecc_pkg::ce),
                    int'($sampled(out_res.ce)));
  due_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && have_head) |-> (out_res.due == (head.cls == ecc_pkg::due)))
    else value_fail("out_res.due", int'($sampled(head.cls) == ecc_pkg::due),
                    int'($sampled(out_res.due)));
  syn_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && have_head) |-> (out_res.syndrome == head.syn))
    else value_fail("out_res.syndrome", int'($sampled(head.syn)),
                    int'($sampled(out_res.syndrome)));
  // Counters land on the same edge as the reference tallies
  ce_cnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    int'(stats.ce_count) == ce_tally)
    else value_fail("stats.ce_count", $sampled(ce_tally), int'($sampled(stats.ce_count)));
  due_cnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    int'(stats.due_count) == due_tally)
    else value_fail("stats.due_count", $sampled(due_tally), int'($sampled(stats.due_count)));
  no_mis_a: assert property (@(posedge clk) disable iff (!rst_n)
    (stats.mismatch_count == '0) && !error)
    else flow_fail("DUT checker reported a mismatch");

  initial begin
    #(limit_cycles * 10);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int a;
    int b;
    int c;
    int ce_before;
    int due_before;
    seed = 32'h32ca_ec12;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    ce_tally = 0;
    due_tally = 0;
    have_head = 1'b0;
    head = '0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_req = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    begin_test();
    check_value("out_valid", 0, int'(out_valid));
    check_value("error", 0, int'(error));
    check_value("stats", 0, int'(stats != '0));
    finish_test("reset");

    begin_test();
    repeat (20) send_word(8'($random(seed)), make_inj(1'b0, 0, 1'b0, 0));
    drain();
    finish_test("clean words");

    // Every position once in back-to-back words
    begin_test();
    ce_before = ce_tally;
    for (int p = 0; p < ecc_pkg::cw_width; p++) begin
      send_word(8'($random(seed)), make_inj(1'b1, p, 1'b0, 0));
    end
    drain();
    check_value("stats.ce_count", ce_before + 13, int'(stats.ce_count));
    finish_test("single errors");

    begin_test();
    due_before = due_tally;
    for (int k = 0; k < 30; k++) begin
      a = $unsigned($random(seed)) % ecc_pkg::cw_width;
      b = (a + 1 + $unsigned($random(seed)) % (ecc_pkg::cw_width - 1)) % ecc_pkg::cw_width;
      send_word(8'($random(seed)), make_inj(1'b1, a, 1'b1, b));
    end
    // Same index twice cancels back to clean
    for (int k = 0; k < 4; k++) begin
      a = $unsigned($random(seed)) % ecc_pkg::cw_width;
      send_word(8'($random(seed)), make_inj(1'b1, a, 1'b1, a));
    end
    drain();
    check_value("stats.due_count", due_before + 30, int'(stats.due_count));
    finish_test("double errors");

    begin_test();
    for (int k = 0; k < 200; k++) begin
      a = $unsigned($random(seed)) % ecc_pkg::cw_width;
      b = (a + 1 + $unsigned($random(seed)) % (ecc_pkg::cw_width - 1)) % ecc_pkg::cw_width;
      c = $unsigned($random(seed)) % 3;
      send_word(8'($random(seed)), make_inj(c > 0, a, c > 1, b));
      idle($unsigned($random(seed)) % (max_gap + 1));
    end
    drain();
    check_value("stats.ce_count", ce_tally, int'(stats.ce_count));
    check_value("stats.due_count", due_tally, int'(stats.due_count));
    check_value("stats.mismatch_count", 0, int'(stats.mismatch_count));
    check_value("error", 0, int'(error));
    finish_test("mixed traffic");

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if ((tests_failed == 0) && (err_count == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
